/* src/rv_isa_pkg.sv */
// RV32I instruction set definitions for the reduced core
// Only the opcodes and funct codes the core decodes are listed here
// Any other encoding is treated as a bubble by the decoder
package rv_isa_pkg;

	// Data, address and instruction word
	typedef logic [31:0] word_t;

	// Register index x0..x31
	typedef logic [4:0] reg_idx_t;

	// Major opcodes, bits [6:0] of the instruction
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	// funct3 codes for register and immediate ALU ops
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct3 codes for branches
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;

	// funct7 selecting SUB over ADD
	localparam logic [6:0] F7_SUB = 7'b0100000;

	// ADDI x0,x0,0, loaded into flushed fetch slots
	localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

/* src/rv_pipe_pkg.sv */
// Pipeline control encodings shared by decode, execute, hazard control
// and the core top level
// The all-zero value of each enum is the safe idle choice
package rv_pipe_pkg;

	// ALU function selected by decode
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B
	} alu_op_e;

	// Source of the register write-back value
	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC4
	} wb_sel_e;

	// Operand source picked by forwarding logic
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_EX_MEM,
		FWD_MEM_WB
	} fwd_sel_e;

	// Per pipe register control
	typedef enum logic [1:0] {
		CTL_ENABLE,
		CTL_STALL,
		CTL_FLUSH
	} stage_ctl_e;

	// Control transfer kind, resolved in EX
	typedef enum logic [1:0] {
		BR_NONE,
		BR_BEQ,
		BR_BNE,
		BR_JUMP
	} br_kind_e;

endpackage

/* src/rv_hazard_ctrl.sv */
// Hazard control for the five-stage pipe, purely combinational
// Taken branch or JAL in EX flushes IF/DEC and DEC/EX
// Load-use in EX stalls PC and IF/DEC and inserts one bubble
// Flush always wins over stall
// EX/MEM and MEM/WB are never held, so they have no control here
`timescale 1ns/1ps

module rv_hazard_ctrl (
	input  rv_isa_pkg::reg_idx_t   dec_rs1,
	input  rv_isa_pkg::reg_idx_t   dec_rs2,
	input  rv_isa_pkg::reg_idx_t   ex_rs1,
	input  rv_isa_pkg::reg_idx_t   ex_rs2,
	input  rv_isa_pkg::reg_idx_t   ex_rd,
	input  rv_isa_pkg::reg_idx_t   mem_rd,
	input  rv_isa_pkg::reg_idx_t   wb_rd,
	input  logic                   ex_mem_re,
	input  logic                   mem_reg_we,
	input  logic                   wb_reg_we,
	input  logic                   branch_taken,
	output rv_pipe_pkg::stage_ctl_e pc_ctl,
	output rv_pipe_pkg::stage_ctl_e if_dec_ctl,
	output rv_pipe_pkg::stage_ctl_e dec_ex_ctl,
	output rv_pipe_pkg::fwd_sel_e   fwd_a,
	output rv_pipe_pkg::fwd_sel_e   fwd_b
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	logic load_use;

	// Newest producer wins, x0 never forwarded
	function automatic fwd_sel_e pick_src(reg_idx_t src, reg_idx_t m_rd, logic m_we,
			reg_idx_t w_rd, logic w_we);
		if (m_we && (m_rd != '0) && (m_rd == src)) begin
			return FWD_EX_MEM;
		end else if (w_we && (w_rd != '0) && (w_rd == src)) begin
			return FWD_MEM_WB;
		end
		return FWD_REG;
	endfunction

	// Load in EX feeding the instruction in DEC
	assign load_use = ex_mem_re && (ex_rd != '0) &&
		((ex_rd == dec_rs1) || (ex_rd == dec_rs2));

	always_comb begin
		pc_ctl     = CTL_ENABLE;
		if_dec_ctl = CTL_ENABLE;
		dec_ex_ctl = CTL_ENABLE;
		if (branch_taken) begin
			// PC takes the target, both younger slots dropped
			if_dec_ctl = CTL_FLUSH;
			dec_ex_ctl = CTL_FLUSH;
		end else if (load_use) begin
			// Hold fetch and decode, bubble into EX
			pc_ctl     = CTL_STALL;
			if_dec_ctl = CTL_STALL;
			dec_ex_ctl = CTL_FLUSH;
		end
	end

	assign fwd_a = pick_src(ex_rs1, mem_rd, mem_reg_we, wb_rd, wb_reg_we);
	assign fwd_b = pick_src(ex_rs2, mem_rd, mem_reg_we, wb_rd, wb_reg_we);

endmodule

/* src/rv_decode.sv */
// Instruction decoder for the RV32I subset
// Source indices are zeroed when the format does not read them,
// so hazard checks never see a false dependency
// Unknown opcodes and unsupported funct3 codes become bubbles
// reg_we is never set for rd = x0
`timescale 1ns/1ps

module rv_decode (
	input  rv_isa_pkg::word_t     instr,
	output rv_isa_pkg::reg_idx_t  rs1,
	output rv_isa_pkg::reg_idx_t  rs2,
	output rv_isa_pkg::reg_idx_t  rd,
	output rv_isa_pkg::word_t     imm,
	output rv_pipe_pkg::alu_op_e  alu_op,
	output logic                  alu_src_imm,
	output logic                  reg_we,
	output logic                  mem_re,
	output logic                  mem_we,
	output rv_pipe_pkg::wb_sel_e  wb_sel,
	output rv_pipe_pkg::br_kind_e br_kind
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	opcode_e    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
	logic       writes_rd;

	assign opcode = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// Immediate formats, all sign extended from bit 31
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		// Bubble by default
		rs1         = '0;
		rs2         = '0;
		rd          = '0;
		imm         = '0;
		alu_op      = ALU_ADD;
		alu_src_imm = 1'b0;
		writes_rd   = 1'b0;
		mem_re      = 1'b0;
		mem_we      = 1'b0;
		wb_sel      = WB_ALU;
		br_kind     = BR_NONE;
		case (opcode)
			OPC_OP: begin
				rs1       = instr[19:15];
				rs2       = instr[24:20];
				rd        = instr[11:7];
				writes_rd = 1'b1;
				case (funct3)
					F3_ADD_SUB: alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
					F3_SLT:     alu_op = ALU_SLT;
					F3_XOR:     alu_op = ALU_XOR;
					F3_OR:      alu_op = ALU_OR;
					F3_AND:     alu_op = ALU_AND;
					default:    writes_rd = 1'b0;
				endcase
			end
			OPC_OP_IMM: begin
				// ADDI only
				rs1         = instr[19:15];
				rd          = instr[11:7];
				imm         = imm_i;
				alu_src_imm = 1'b1;
				writes_rd   = (funct3 == F3_ADD_SUB);
			end
			OPC_LUI: begin
				rd          = instr[11:7];
				imm         = imm_u;
				alu_op      = ALU_PASS_B;
				alu_src_imm = 1'b1;
				writes_rd   = 1'b1;
			end
			OPC_LOAD: begin
				// Word access assumed
				rs1         = instr[19:15];
				rd          = instr[11:7];
				imm         = imm_i;
				alu_src_imm = 1'b1;
				writes_rd   = 1'b1;
				mem_re      = 1'b1;
				wb_sel      = WB_MEM;
			end
			OPC_STORE: begin
				rs1         = instr[19:15];
				rs2         = instr[24:20];
				imm         = imm_s;
				alu_src_imm = 1'b1;
				mem_we      = 1'b1;
			end
			OPC_BRANCH: begin
				rs1 = instr[19:15];
				rs2 = instr[24:20];
				imm = imm_b;
				if (funct3 == F3_BEQ) begin
					br_kind = BR_BEQ;
				end else if (funct3 == F3_BNE) begin
					br_kind = BR_BNE;
				end
			end
			OPC_JAL: begin
				// Link value comes from the PC+4 chain
				rd        = instr[11:7];
				imm       = imm_j;
				writes_rd = 1'b1;
				wb_sel    = WB_PC4;
				br_kind   = BR_JUMP;
			end
			default: begin
			end
		endcase
	end

	assign reg_we = writes_rd && (rd != '0);

endmodule

/* src/rv_regfile.sv */
// 32 x 32 register file, two combinational reads, one write at the edge
// x0 is never written and reads as zero
// A write in the same cycle is visible on the read ports
`timescale 1ns/1ps

module rv_regfile (
	input  logic                 CLK,
	input  logic                 rst_n,
	input  rv_isa_pkg::reg_idx_t rs1,
	input  rv_isa_pkg::reg_idx_t rs2,
	output rv_isa_pkg::word_t    rs1_data,
	output rv_isa_pkg::word_t    rs2_data,
	input  logic                 we,
	input  rv_isa_pkg::reg_idx_t rd,
	input  rv_isa_pkg::word_t    wdata
);
	import rv_isa_pkg::*;

	word_t regs [32];

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (rd != '0)) begin
			regs[rd] <= wdata;
		end
	end

	// Write-through covers the WB to DEC distance
	assign rs1_data = (we && (rd != '0) && (rd == rs1)) ? wdata : regs[rs1];
	assign rs2_data = (we && (rd != '0) && (rd == rs2)) ? wdata : regs[rs2];

endmodule

/* src/rv_execute.sv */
// Execute stage datapath, purely combinational
// Operand forwarding, ALU, branch compare and target adder
// Branch compare uses the register operands, never the immediate
// store_data is the forwarded rs2 value
`timescale 1ns/1ps

module rv_execute (
	input  rv_isa_pkg::word_t     pc,
	input  rv_isa_pkg::word_t     rs1_data,
	input  rv_isa_pkg::word_t     rs2_data,
	input  rv_isa_pkg::word_t     imm,
	input  rv_isa_pkg::word_t     fwd_mem_data,
	input  rv_isa_pkg::word_t     fwd_wb_data,
	input  rv_pipe_pkg::fwd_sel_e fwd_a,
	input  rv_pipe_pkg::fwd_sel_e fwd_b,
	input  rv_pipe_pkg::alu_op_e  alu_op,
	input  logic                  alu_src_imm,
	input  rv_pipe_pkg::br_kind_e br_kind,
	output rv_isa_pkg::word_t     alu_result,
	output rv_isa_pkg::word_t     store_data,
	output rv_isa_pkg::word_t     branch_target,
	output logic                  branch_taken
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	word_t op_a, op_b_reg, op_b;

	function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
			word_t wb_val);
		case (sel)
			FWD_EX_MEM: return mem_val;
			FWD_MEM_WB: return wb_val;
			default:    return reg_val;
		endcase
	endfunction

	assign op_a       = fwd_mux(fwd_a, rs1_data, fwd_mem_data, fwd_wb_data);
	assign op_b_reg   = fwd_mux(fwd_b, rs2_data, fwd_mem_data, fwd_wb_data);
	assign op_b       = alu_src_imm ? imm : op_b_reg;
	assign store_data = op_b_reg;

	always_comb begin
		case (alu_op)
			ALU_SUB:    alu_result = op_a - op_b;
			ALU_AND:    alu_result = op_a & op_b;
			ALU_OR:     alu_result = op_a | op_b;
			ALU_XOR:    alu_result = op_a ^ op_b;
			// Signed less-than
			ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_PASS_B: alu_result = op_b;
			default:    alu_result = op_a + op_b;
		endcase
	end

	always_comb begin
		case (br_kind)
			BR_BEQ:  branch_taken = (op_a == op_b_reg);
			BR_BNE:  branch_taken = (op_a != op_b_reg);
			BR_JUMP: branch_taken = 1'b1;
			default: branch_taken = 1'b0;
		endcase
	end

	// Same adder serves branches and JAL
	assign branch_target = pc + imm;

endmodule

/* src/rv_core.sv */
// Five-stage RV32I subset core: IF, DEC, EX, MEM, WB
// Instruction and data memories must answer combinationally, no wait states
// Branches and JAL resolve in EX, two bubbles when taken
// Load-use costs one bubble, everything else is forwarded
// Retire port mirrors the register file write, one pulse per write
`timescale 1ns/1ps

module rv_core (
	input  logic                 CLK,
	input  logic                 rst_n,
	output rv_isa_pkg::word_t    imem_addr,
	input  rv_isa_pkg::word_t    imem_rdata,
	output rv_isa_pkg::word_t    dmem_addr,
	output rv_isa_pkg::word_t    dmem_wdata,
	output logic                 dmem_we,
	output logic                 dmem_re,
	input  rv_isa_pkg::word_t    dmem_rdata,
	output logic                 wb_we,
	output rv_isa_pkg::reg_idx_t wb_rd,
	output rv_isa_pkg::word_t    wb_data
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	// Fetch
	word_t pc, pc4, next_pc;

	// Hazard control
	stage_ctl_e pc_ctl, if_dec_ctl, dec_ex_ctl;
	fwd_sel_e   fwd_a, fwd_b;

	// IF/DEC
	word_t id_instr, id_pc, id_pc4;

	// Decode outputs
	reg_idx_t dec_rs1, dec_rs2, dec_rd;
	word_t    dec_imm, dec_rs1_data, dec_rs2_data;
	alu_op_e  dec_alu_op;
	logic     dec_alu_src_imm, dec_reg_we, dec_mem_re, dec_mem_we;
	wb_sel_e  dec_wb_sel;
	br_kind_e dec_br_kind;

	// DEC/EX
	word_t    ex_pc, ex_pc4, ex_rs1_data, ex_rs2_data, ex_imm;
	reg_idx_t ex_rs1, ex_rs2, ex_rd;
	alu_op_e  ex_alu_op;
	logic     ex_alu_src_imm, ex_reg_we, ex_mem_re, ex_mem_we;
	wb_sel_e  ex_wb_sel;
	br_kind_e ex_br_kind;

	// Execute outputs
	word_t alu_result, store_data, branch_target;
	logic  branch_taken;

	// EX/MEM
	word_t    mem_alu, mem_store_data, mem_pc4, mem_fwd_data;
	reg_idx_t mem_rd;
	logic     mem_reg_we, mem_mem_re, mem_mem_we;
	wb_sel_e  mem_wb_sel;

	// MEM/WB
	word_t   wb_alu, wb_mem_data, wb_pc4;
	wb_sel_e wb_wb_sel;

	assign pc4       = pc + 32'd4;
	assign next_pc   = branch_taken ? branch_target : pc4;
	assign imem_addr = pc;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (pc_ctl == CTL_ENABLE) begin
			pc <= next_pc;
		end
	end

	// IF/DEC, flush drops in a NOP
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			id_instr <= NOP_INSTR;
		end else if (if_dec_ctl == CTL_FLUSH) begin
			id_instr <= NOP_INSTR;
		end else if (if_dec_ctl == CTL_ENABLE) begin
			id_instr <= imem_rdata;
		end
	end

	always_ff @(posedge CLK) begin
		if (if_dec_ctl == CTL_ENABLE) begin
			id_pc  <= pc;
			id_pc4 <= pc4;
		end
	end

	rv_decode u_decode (
		.instr       (id_instr),
		.rs1         (dec_rs1),
		.rs2         (dec_rs2),
		.rd          (dec_rd),
		.imm         (dec_imm),
		.alu_op      (dec_alu_op),
		.alu_src_imm (dec_alu_src_imm),
		.reg_we      (dec_reg_we),
		.mem_re      (dec_mem_re),
		.mem_we      (dec_mem_we),
		.wb_sel      (dec_wb_sel),
		.br_kind     (dec_br_kind)
	);

	rv_regfile u_regfile (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.rs1      (dec_rs1),
		.rs2      (dec_rs2),
		.rs1_data (dec_rs1_data),
		.rs2_data (dec_rs2_data),
		.we       (wb_we),
		.rd       (wb_rd),
		.wdata    (wb_data)
	);

	// DEC/EX control bits, cleared on flush
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			ex_reg_we  <= 1'b0;
			ex_mem_re  <= 1'b0;
			ex_mem_we  <= 1'b0;
			ex_br_kind <= BR_NONE;
		end else if (dec_ex_ctl == CTL_FLUSH) begin
			ex_reg_we  <= 1'b0;
			ex_mem_re  <= 1'b0;
			ex_mem_we  <= 1'b0;
			ex_br_kind <= BR_NONE;
		end else if (dec_ex_ctl == CTL_ENABLE) begin
			ex_reg_we  <= dec_reg_we;
			ex_mem_re  <= dec_mem_re;
			ex_mem_we  <= dec_mem_we;
			ex_br_kind <= dec_br_kind;
		end
	end

	// DEC/EX payload
	always_ff @(posedge CLK) begin
		if (dec_ex_ctl == CTL_ENABLE) begin
			ex_pc          <= id_pc;
			ex_pc4         <= id_pc4;
			ex_rs1_data    <= dec_rs1_data;
			ex_rs2_data    <= dec_rs2_data;
			ex_imm         <= dec_imm;
			ex_rs1         <= dec_rs1;
			ex_rs2         <= dec_rs2;
			ex_rd          <= dec_rd;
			ex_alu_op      <= dec_alu_op;
			ex_alu_src_imm <= dec_alu_src_imm;
			ex_wb_sel      <= dec_wb_sel;
		end
	end

	rv_hazard_ctrl u_hazard (
		.dec_rs1      (dec_rs1),
		.dec_rs2      (dec_rs2),
		.ex_rs1       (ex_rs1),
		.ex_rs2       (ex_rs2),
		.ex_rd        (ex_rd),
		.mem_rd       (mem_rd),
		.wb_rd        (wb_rd),
		.ex_mem_re    (ex_mem_re),
		.mem_reg_we   (mem_reg_we),
		.wb_reg_we    (wb_we),
		.branch_taken (branch_taken),
		.pc_ctl       (pc_ctl),
		.if_dec_ctl   (if_dec_ctl),
		.dec_ex_ctl   (dec_ex_ctl),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b)
	);

	// A JAL in MEM forwards its link value
	assign mem_fwd_data = (mem_wb_sel == WB_PC4) ? mem_pc4 : mem_alu;

	rv_execute u_execute (
		.pc            (ex_pc),
		.rs1_data      (ex_rs1_data),
		.rs2_data      (ex_rs2_data),
		.imm           (ex_imm),
		.fwd_mem_data  (mem_fwd_data),
		.fwd_wb_data   (wb_data),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.alu_op        (ex_alu_op),
		.alu_src_imm   (ex_alu_src_imm),
		.br_kind       (ex_br_kind),
		.alu_result    (alu_result),
		.store_data    (store_data),
		.branch_target (branch_target),
		.branch_taken  (branch_taken)
	);

	// EX/MEM and MEM/WB never stall
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			mem_reg_we <= 1'b0;
			mem_mem_re <= 1'b0;
			mem_mem_we <= 1'b0;
			wb_we      <= 1'b0;
		end else begin
			mem_reg_we <= ex_reg_we;
			mem_mem_re <= ex_mem_re;
			mem_mem_we <= ex_mem_we;
			wb_we      <= mem_reg_we;
		end
	end

	always_ff @(posedge CLK) begin
		mem_alu        <= alu_result;
		mem_store_data <= store_data;
		mem_pc4        <= ex_pc4;
		mem_rd         <= ex_rd;
		mem_wb_sel     <= ex_wb_sel;
		wb_alu         <= mem_alu;
		wb_mem_data    <= dmem_rdata;
		wb_pc4         <= mem_pc4;
		wb_rd          <= mem_rd;
		wb_wb_sel      <= mem_wb_sel;
	end

	// Data port straight from EX/MEM
	assign dmem_addr  = mem_alu;
	assign dmem_wdata = mem_store_data;
	assign dmem_we    = mem_mem_we;
	assign dmem_re    = mem_mem_re;

	// Write-back select
	always_comb begin
		case (wb_wb_sel)
			WB_MEM:  wb_data = wb_mem_data;
			WB_PC4:  wb_data = wb_pc4;
			default: wb_data = wb_alu;
		endcase
	end

endmodule

/* sim/rv_core_tb.sv */
// Testbench for rv_core with combinational instruction and data memories
// Program, initial data and expected results come from sim/core_input.dat
// Run from the project root so the data file path resolves
// Memories: 64 instruction words, 256 data words, word accesses only
// Stops at the first mismatch, or after 8 x program length + 100 cycles
`timescale 1ns/1ps

module rv_core_tb;
	import rv_isa_pkg::*;

	logic     CLK;
	logic     rst_n;
	word_t    imem_addr, imem_rdata;
	word_t    dmem_addr, dmem_wdata, dmem_rdata;
	logic     dmem_we, dmem_re;
	logic     wb_we;
	reg_idx_t wb_rd;
	word_t    wb_data;

	// Memory models
	word_t imem [64];
	word_t dmem [256];

	// Expected results in retire order
	reg_idx_t exp_wb_rd [$];
	word_t    exp_wb_data [$];
	word_t    exp_st_addr [$];
	word_t    exp_st_data [$];

	int prog_len    = 0;
	int wb_idx      = 0;
	int st_idx      = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	rv_core uut (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_re    (dmem_re),
		.dmem_rdata (dmem_rdata),
		.wb_we      (wb_we),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data)
	);

	// Combinational reads, word indexed
	assign imem_rdata = imem[imem_addr[7:2]];
	// Read data only valid while dmem_re is high
	assign dmem_rdata = dmem_re ? dmem[dmem_addr[9:2]] : 'x;

	// Store lands at the rising edge
	always @(posedge CLK) begin
		if (dmem_we) begin
			dmem[dmem_addr[9:2]] <= dmem_wdata;
		end
	end

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	task automatic stop_on_error();
		$display("Some tests failed");
		$fatal(1, "run stopped at %0d ns", $time);
	endtask

	task automatic check_level(input string name, input logic exp_val, input logic act_val);
		if (act_val !== exp_val) begin
			$display("** Error at %0d ns: %s expected %b, got %b", $time, name, exp_val, act_val);
			stop_on_error();
		end
	endtask

	task automatic check_addr(input string name, input word_t exp_val, input word_t act_val);
		if (act_val !== exp_val) begin
			$display("** Error at %0d ns: %s expected %h, got %h", $time, name, exp_val, act_val);
			stop_on_error();
		end
	endtask

	task automatic check_wb(input reg_idx_t exp_rd, input word_t exp_data);
		if (wb_rd !== exp_rd) begin
			$display("** Error at %0d ns: wb_rd expected x%0d, got x%0d", $time, exp_rd, wb_rd);
			stop_on_error();
		end else if (wb_data !== exp_data) begin
			$display("** Error at %0d ns: wb_data for x%0d expected %h, got %h",
				$time, exp_rd, exp_data, wb_data);
			stop_on_error();
		end
	endtask

	task automatic check_store(input word_t exp_addr, input word_t exp_data);
		if (dmem_addr !== exp_addr) begin
			$display("** Error at %0d ns: dmem_addr expected %h, got %h", $time, exp_addr, dmem_addr);
			stop_on_error();
		end else if (dmem_wdata !== exp_data) begin
			$display("** Error at %0d ns: dmem_wdata expected %h, got %h",
				$time, exp_data, dmem_wdata);
			stop_on_error();
		end
	endtask

	// Strobes quiet, fetch pointer checked only while in reset
	task automatic check_idle(input logic check_pc);
		check_level("wb_we", 1'b0, wb_we);
		check_level("dmem_we", 1'b0, dmem_we);
		check_level("dmem_re", 1'b0, dmem_re);
		if (check_pc) begin
			check_addr("imem_addr", 32'h0, imem_addr);
		end
	endtask

	// Tagged lines: P word, D addr data, W rd data, S addr data, # comment
	task automatic load_input();
		int    fd;
		int    c;
		int    n;
		int    rd_val;
		word_t a;
		word_t b;
		for (int i = 0; i < 64; i++) begin
			imem[i] = NOP_INSTR;
		end
		for (int i = 0; i < 256; i++) begin
			dmem[i] = '0;
		end
		fd = $fopen("sim/core_input.dat", "r");
		if (fd == 0) begin
			$display("Could not open the data file sim/core_input.dat");
			stop_on_error();
		end else begin
			c = $fgetc(fd);
			while (c != -1) begin
				n = 1;
				case (c)
					"#": begin
						while ((c != "\n") && (c != -1)) begin
							c = $fgetc(fd);
						end
					end
					"P": begin
						n = $fscanf(fd, " %h", a);
						if (prog_len >= 64) begin
							$display("Program in the data file does not fit in 64 words");
							stop_on_error();
						end else begin
							imem[prog_len] = a;
							prog_len++;
						end
					end
					"D": begin
						n = $fscanf(fd, " %h %h", a, b) - 1;
						dmem[a[9:2]] = b;
					end
					"W": begin
						n = $fscanf(fd, " %d %h", rd_val, b) - 1;
						exp_wb_rd.push_back(reg_idx_t'(rd_val));
						exp_wb_data.push_back(b);
					end
					"S": begin
						n = $fscanf(fd, " %h %h", a, b) - 1;
						exp_st_addr.push_back(a);
						exp_st_data.push_back(b);
					end
					" ", "\t", "\r", "\n": begin
					end
					default: begin
						$display("Unknown tag character %0d in the data file", c);
						stop_on_error();
					end
				endcase
				if (n != 1) begin
					$display("Malformed line in the data file after %0d program words", prog_len);
					stop_on_error();
				end
				c = $fgetc(fd);
			end
			$fclose(fd);
		end
	endtask

	// Retire port, store port and data address range
	task automatic check_ports();
		if (wb_we) begin
			if (wb_idx >= exp_wb_rd.size()) begin
				$display("Unexpected register write at %0d ns: x%0d written with %h",
					$time, wb_rd, wb_data);
				stop_on_error();
			end else begin
				check_wb(exp_wb_rd[wb_idx], exp_wb_data[wb_idx]);
				wb_idx++;
			end
		end
		if ((dmem_we || dmem_re) && ((dmem_addr >= 32'd1024) || (dmem_addr[1:0] != 2'b00))) begin
			$display("Data access at %0d ns outside the model or unaligned: %h", $time, dmem_addr);
			stop_on_error();
		end
		if (dmem_we) begin
			if (st_idx >= exp_st_addr.size()) begin
				$display("Unexpected store at %0d ns: %h written to %h",
					$time, dmem_wdata, dmem_addr);
				stop_on_error();
			end else begin
				check_store(exp_st_addr[st_idx], exp_st_data[st_idx]);
				st_idx++;
			end
		end
	endtask

	// Cycle budget scales with program length
	initial begin
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge CLK);
			cycle_count++;
		end
		$display("Timeout after %0d cycles: %0d of %0d writes and %0d of %0d stores seen",
			cycle_count, wb_idx, exp_wb_rd.size(), st_idx, exp_st_addr.size());
		stop_on_error();
	end

	initial begin
		rst_n = 1'b0;
		load_input();
		cycle_limit = 8 * prog_len + 100;
		// Reset held for 8 cycles, released on a falling edge
		repeat (8) begin
			@(negedge CLK);
			check_idle(1'b1);
		end
		rst_n = 1'b1;
		// First cycle out of reset, pipe still empty
		@(negedge CLK);
		check_idle(1'b0);
		while ((wb_idx < exp_wb_rd.size()) || (st_idx < exp_st_addr.size())) begin
			@(negedge CLK);
			check_ports();
		end
		// Program parks in its JAL loop, nothing more may retire
		repeat (10) begin
			@(negedge CLK);
			check_ports();
		end
		$display("All tests passed");
		$finish;
	end

endmodule

/* files.f */
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/rv_hazard_ctrl.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_core.sv
sim/rv_core_tb.sv

/* sim/core_input.dat */
# P: program word (hex), placed from address 0 in order
# D: data address (hex) and initial word (hex); W: rd (decimal) and value (hex); S: address and value (hex)
P 00500093  # 00 addi x1, x0, 5
P ffd00113  # 04 addi x2, x0, -3
P 002081b3  # 08 add  x3, x1, x2
P 40118233  # 0c sub  x4, x3, x1
P 001222b3  # 10 slt  x5, x4, x1
P 0020a333  # 14 slt  x6, x1, x2
P 123453b7  # 18 lui  x7, 0x12345
P 0013c433  # 1c xor  x8, x7, x1
P 002464b3  # 20 or   x9, x8, x2
P 0074f533  # 24 and  x10, x9, x7
P 00708013  # 28 addi x0, x1, 7
P 001005b3  # 2c add  x11, x0, x1
P 04000613  # 30 addi x12, x0, 0x40
P 00062683  # 34 lw   x13, 0(x12)
P 00168713  # 38 addi x14, x13, 1
P 00e62223  # 3c sw   x14, 4(x12)
P 00462783  # 40 lw   x15, 4(x12)
P 00862803  # 44 lw   x16, 8(x12)
P 00b08663  # 48 beq  x1, x11, +12
P 00100a13  # 4c addi x20, x0, 1
P 00100a93  # 50 addi x21, x0, 1
P 00b09463  # 54 bne  x1, x11, +8
P 00900893  # 58 addi x17, x0, 9
P 01181663  # 5c bne  x16, x17, +12
P 00200a13  # 60 addi x20, x0, 2
P 00200a93  # 64 addi x21, x0, 2
P 00c0096f  # 68 jal  x18, +12
P 00300a13  # 6c addi x20, x0, 3
P 00300a93  # 70 addi x21, x0, 3
P 011909b3  # 74 add  x19, x18, x17
P 01362023  # 78 sw   x19, 0(x12)
P 0000006f  # 7c jal  x0, 0
# Initial data words
D 00000040 cafe0001
D 00000044 11111111
D 00000048 00000007
# Register writes in retire order
W 1 00000005
W 2 fffffffd
W 3 00000002
W 4 fffffffd
W 5 00000001
W 6 00000000
W 7 12345000
W 8 12345005
W 9 fffffffd
W 10 12345000
W 11 00000005
W 12 00000040
W 13 cafe0001
W 14 cafe0002
W 15 cafe0002
W 16 00000007
W 17 00000009
W 18 0000006c
W 19 00000075
# Stores in order
S 00000044 cafe0002
S 00000040 00000075
